/* alu.sv */
`default_nettype none

module alu (
    input  wire rvCorePkg::wordT a,
    input  wire rvCorePkg::wordT b,
    input  wire rvIsaPkg::aluOpT op,
    output rvCorePkg::wordT      result,
    output logic                 zero
);

    always_comb begin
        result = '0;
        case (op)
            rvIsaPkg::aluAnd: result = a & b;
            rvIsaPkg::aluOr:  result = a | b;
            rvIsaPkg::aluAdd: result = a + b;
            rvIsaPkg::aluSub: result = a - b;
            rvIsaPkg::aluSlt: begin
                // two's complement compare, 1 or 0
                result[0] = $signed(a) < $signed(b);
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // beq resolves on this
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* controlDecoder.sv */
`default_nettype none

module controlDecoder (
    input  wire rvIsaPkg::instrU instr,
    output rvCorePkg::ctrlT      ctrl
);

    // r-type alu op from funct3 / funct7
    rvIsaPkg::aluOpT regAluOp;

    always_comb begin
        case (instr.r.funct3)
            rvIsaPkg::f3AddSub: begin
                // funct7 bit 5 picks sub
                if (instr.r.funct7[5]) begin
                    regAluOp = rvIsaPkg::aluSub;
                end else begin
                    regAluOp = rvIsaPkg::aluAdd;
                end
            end
            rvIsaPkg::f3Slt: regAluOp = rvIsaPkg::aluSlt;
            rvIsaPkg::f3Or:  regAluOp = rvIsaPkg::aluOr;
            rvIsaPkg::f3And: regAluOp = rvIsaPkg::aluAnd;
            // outside the subset, result unused
            default:         regAluOp = rvIsaPkg::aluAdd;
        endcase
    end

    // ====================
    // opcode decode
    // ====================
    always_comb begin
        // everything off, unknown opcodes only advance pc
        ctrl.regWrite  = 1'b0;
        ctrl.aluSrcImm = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.jal       = 1'b0;
        ctrl.jalr      = 1'b0;
        ctrl.wbSel     = rvCorePkg::wbAlu;
        ctrl.aluOp     = rvIsaPkg::aluAdd;

        case (instr.r.opcode)
            rvIsaPkg::opReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = regAluOp;
            end
            rvIsaPkg::opLoad: begin
                // address = rs1 + imm
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSel     = rvCorePkg::wbMem;
            end
            rvIsaPkg::opStore: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
            end
            rvIsaPkg::opBranch: begin
                // beq only, equal when difference is zero
                ctrl.branch = 1'b1;
                ctrl.aluOp  = rvIsaPkg::aluSub;
            end
            rvIsaPkg::opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jal      = 1'b1;
                ctrl.wbSel    = rvCorePkg::wbLink;
            end
            rvIsaPkg::opJalr: begin
                // target formed in pcUnit
                ctrl.regWrite = 1'b1;
                ctrl.jalr     = 1'b1;
                ctrl.wbSel    = rvCorePkg::wbLink;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* coreChecks_props.sv */
`default_nettype none

module coreChecks_props (
    input wire                     clk,
    input wire                     rst_n,
    input wire rvCorePkg::wordT    pc,
    input wire rvCorePkg::ctrlT    ctrl,
    input wire rvCorePkg::dmemReqT dmemReq,
    input wire rvCorePkg::retireT  retire
);

    // fetch stays on word boundaries
    pcAligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else $error("pc %h not word aligned", pc);

    // a store never writes the register file
    noDualWrite: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmemReq.writeEn && retire.regWrite))
        else $error("store and register write in one cycle");

    // ====================
    // sequential flow
    // ====================
    // straight-line instruction falls through, reset edges excluded
    seqAdvance: assert property (@(posedge clk) disable iff (!rst_n)
        (rst_n && !(ctrl.jal || ctrl.jalr || ctrl.branch))
        |=> (!rst_n || pc == $past(pc) + 32'd4))
        else $error("pc %h did not advance by 4", pc);

endmodule

bind riscvCore coreChecks_props coreChecks_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .pc      (pc),
    .ctrl    (ctrl),
    .dmemReq (dmemReq),
    .retire  (retire)
);

`default_nettype wire

/* immGen.sv */
`default_nettype none

module immGen (
    input  wire rvIsaPkg::instrU instr,
    output rvCorePkg::wordT      imm
);

    // sign bit is instr[31] for every format
    always_comb begin
        case (instr.r.opcode)
            // i layout
            rvIsaPkg::opLoad,
            rvIsaPkg::opJalr: begin
                imm = {{20{instr.i.imm11to0[11]}}, instr.i.imm11to0};
            end
            // s layout, split around rs1/rs2
            rvIsaPkg::opStore: begin
                imm = {{20{instr.s.imm11to5[6]}}, instr.s.imm11to5, instr.s.imm4to0};
            end
            // b layout, halfword offset
            rvIsaPkg::opBranch: begin
                imm = {{19{instr.b.imm12}},
                       instr.b.imm12,
                       instr.b.imm11,
                       instr.b.imm10to5,
                       instr.b.imm4to1,
                       1'b0};
            end
            // j layout, 21-bit offset
            rvIsaPkg::opJal: begin
                imm = {{11{instr.j.imm20}},
                       instr.j.imm20,
                       instr.j.imm19to12,
                       instr.j.imm11,
                       instr.j.imm10to1,
                       1'b0};
            end
            // r-type and unknown
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* pcUnit.sv */
`default_nettype none

module pcUnit (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire rvCorePkg::ctrlT ctrl,
    input  wire                  zero,
    input  wire rvCorePkg::wordT imm,
    input  wire rvCorePkg::wordT rs1Data,
    output rvCorePkg::wordT      pc,
    output rvCorePkg::wordT      pcPlus4
);

    rvCorePkg::wordT pcNext;

    // also the link value for jal/jalr
    assign pcPlus4 = pc + 32'd4;

    // jalr wins, then pc-relative jump or taken beq
    always_comb begin
        if (ctrl.jalr) begin
            pcNext = rs1Data + imm;
        end else if (ctrl.jal || (ctrl.branch && zero)) begin
            pcNext = pc + imm;
        end else begin
            pcNext = pcPlus4;
        end
    end

    // one instruction per edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire rvIsaPkg::regAddrT rs1,
    input  wire rvIsaPkg::regAddrT rs2,
    output rvCorePkg::wordT        rs1Data,
    output rvCorePkg::wordT        rs2Data,
    input  wire rvIsaPkg::regAddrT rd,
    input  wire rvCorePkg::wordT   wrData,
    input  wire                    wrEn
);

    rvCorePkg::wordT regs [32];

    // combinational read, x0 reads as zero
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

    // write on the retiring edge, x0 never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int idx = 0; idx < 32; idx++) begin
                regs[idx] <= '0;
            end
        end else if (wrEn && (rd != '0)) begin
            regs[rd] <= wrData;
        end
    end

endmodule

`default_nettype wire

/* riscvCore.sv */
`default_nettype none

module riscvCore (
    input  wire                     clk,
    input  wire                     rst_n,
    output rvCorePkg::wordT         pc,
    input  wire rvCorePkg::wordT    instr,
    output rvCorePkg::dmemReqT      dmemReq,
    input  wire rvCorePkg::wordT    dmemRdata,
    output rvCorePkg::retireT       retire
);

    rvIsaPkg::instrU decoded;
    rvCorePkg::ctrlT ctrl;
    rvCorePkg::wordT imm;
    rvCorePkg::wordT rs1Data;
    rvCorePkg::wordT rs2Data;
    rvCorePkg::wordT aluB;
    rvCorePkg::wordT aluResult;
    rvCorePkg::wordT loadData;
    rvCorePkg::wordT pcPlus4;
    rvCorePkg::wordT wbData;
    logic            zero;

    // ====================
    // byte lanes
    // ====================
    // memories hold words big-endian, core works little-endian
    assign decoded  = {<<8{instr}};
    assign loadData = {<<8{dmemRdata}};

    // decode and immediate
    controlDecoder controlDecoder_inst (
        .instr (decoded),
        .ctrl  (ctrl)
    );

    immGen immGen_inst (
        .instr (decoded),
        .imm   (imm)
    );

    // rs/rd fields sit in the same place in every format
    regFile regFile_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (decoded.r.rs1),
        .rs2     (decoded.r.rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .rd      (decoded.r.rd),
        .wrData  (wbData),
        .wrEn    (ctrl.regWrite)
    );

    // second operand, imm for lw/sw
    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

    alu alu_inst (
        .a      (rs1Data),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (zero)
    );

    pcUnit pcUnit_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .zero    (zero),
        .imm     (imm),
        .rs1Data (rs1Data),
        .pc      (pc),
        .pcPlus4 (pcPlus4)
    );

    // ====================
    // writeback
    // ====================
    always_comb begin
        case (ctrl.wbSel)
            rvCorePkg::wbMem:  wbData = loadData;
            rvCorePkg::wbLink: wbData = pcPlus4;
            default:           wbData = aluResult;
        endcase
    end

    // word index from address bits 8:2
    assign dmemReq.wordAddr  = aluResult[rvCorePkg::dmemAddrW+1:2];
    // store data back to memory byte order
    assign dmemReq.writeData = {<<8{rs2Data}};
    assign dmemReq.writeEn   = ctrl.memWrite;

    // observation of the register write
    assign retire.regWrite = ctrl.regWrite;
    assign retire.rd       = decoded.r.rd;
    assign retire.data     = wbData;

endmodule

`default_nettype wire

/* riscvCoreTb.sv */
`default_nettype none

module riscvCoreTb;

    logic                clk;
    logic                rst_n;
    rvCorePkg::wordT     pc;
    rvCorePkg::wordT     instr;
    rvCorePkg::dmemReqT  dmemReq;
    rvCorePkg::wordT     dmemRdata;
    rvCorePkg::retireT   retire;

    // both memories hold words big-endian
    rvCorePkg::wordT rom [64];
    rvCorePkg::wordT ram [128];

    int seed         = 32'h6bd421cb;
    int errorCount   = 0;
    int timeoutCount = 0;

    riscvCore riscvCore_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc        (pc),
        .instr     (instr),
        .dmemReq   (dmemReq),
        .dmemRdata (dmemRdata),
        .retire    (retire)
    );

    always #50 clk = ~clk;

    // ====================
    // memory models
    // ====================
    // combinational read ports
    assign instr     = rom[pc[7:2]];
    assign dmemRdata = ram[dmemReq.wordAddr];

    // store commits on the retiring edge
    always @(posedge clk) begin
        if (rst_n && dmemReq.writeEn) begin
            ram[dmemReq.wordAddr] <= dmemReq.writeData;
        end
    end

    function automatic rvCorePkg::wordT toBigEndian(input rvCorePkg::wordT w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // ====================
    // instruction encoders
    // ====================
    function automatic rvCorePkg::wordT rInstr(input logic [6:0] f7, input logic [2:0] f3,
            input rvIsaPkg::regAddrT rd, input rvIsaPkg::regAddrT rs1,
            input rvIsaPkg::regAddrT rs2);
        return {f7, rs2, rs1, f3, rd, rvIsaPkg::opReg};
    endfunction

    function automatic rvCorePkg::wordT lwInstr(input rvIsaPkg::regAddrT rd,
            input logic [11:0] off, input rvIsaPkg::regAddrT rs1);
        return {off, rs1, 3'b010, rd, rvIsaPkg::opLoad};
    endfunction

    // offset split around the two source fields
    function automatic rvCorePkg::wordT swInstr(input rvIsaPkg::regAddrT rs2,
            input logic [11:0] off, input rvIsaPkg::regAddrT rs1);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], rvIsaPkg::opStore};
    endfunction

    function automatic rvCorePkg::wordT beqInstr(input rvIsaPkg::regAddrT rs1,
            input rvIsaPkg::regAddrT rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], rvIsaPkg::opBranch};
    endfunction

    function automatic rvCorePkg::wordT jalInstr(input rvIsaPkg::regAddrT rd,
            input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::opJal};
    endfunction

    function automatic rvCorePkg::wordT jalrInstr(input rvIsaPkg::regAddrT rd,
            input rvIsaPkg::regAddrT rs1, input logic [11:0] off);
        return {off, rs1, 3'b000, rd, rvIsaPkg::opJalr};
    endfunction

    task automatic putInstr(input int idx, input rvCorePkg::wordT w);
        rom[idx] <= toBigEndian(w);
    endtask

    // opcode 0 everywhere, index in the upper bits
    task automatic fillRom();
        for (int idx = 0; idx < 64; idx++) begin
            rom[idx] <= toBigEndian({idx[24:0], 7'b0000000});
        end
    endtask

    task automatic fillRam();
        for (int a = 0; a < 128; a++) begin
            ram[a] <= toBigEndian({8'hc3, 1'b0, a[6:0], 1'b0, a[6:0], 1'b0, a[6:0]});
        end
    endtask

    // ====================
    // sequencing
    // ====================
    task automatic step();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic holdReset();
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
    endtask

    // low for 3 cycles in all, sample point after release
    task automatic releaseReset();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
    endtask

    task automatic finishRun();
        $display("value errors: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic waitForPc(input rvCorePkg::wordT target, input int limit);
        int cycles;
        cycles = 0;
        while (pc !== target && cycles < limit) begin
            step();
            cycles++;
        end
        if (pc !== target) begin
            $display("timeout: pc never reached %h within %0d cycles", target, limit);
            timeoutCount++;
            finishRun();
        end
    endtask

    // ====================
    // compare tasks
    // ====================
    task automatic checkWord(input string what, input rvCorePkg::wordT got,
            input rvCorePkg::wordT exp);
        if (got !== exp) begin
            errorCount++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // address and data matter on a store only
    task automatic checkReq(input string what, input rvCorePkg::dmemReqT got,
            input rvCorePkg::dmemReqT exp);
        if (got.writeEn !== exp.writeEn || (exp.writeEn && got !== exp)) begin
            errorCount++;
            $display("Fail at %0t: %s request %h/%h/%b, expected %h/%h/%b", $time, what,
                got.wordAddr, got.writeData, got.writeEn,
                exp.wordAddr, exp.writeData, exp.writeEn);
        end
    endtask

    // rd and data matter on a register write only
    task automatic checkRetire(input string what, input rvCorePkg::retireT got,
            input rvCorePkg::retireT exp);
        if (got.regWrite !== exp.regWrite || (exp.regWrite && got !== exp)) begin
            errorCount++;
            $display("Fail at %0t: %s retire %b x%0d=%h, expected %b x%0d=%h", $time, what,
                got.regWrite, got.rd, got.data, exp.regWrite, exp.rd, exp.data);
        end
    endtask

    function automatic rvCorePkg::retireT writeOf(input rvIsaPkg::regAddrT rd,
            input rvCorePkg::wordT data);
        rvCorePkg::retireT r;
        r.regWrite = 1'b1;
        r.rd       = rd;
        r.data     = data;
        return r;
    endfunction

    function automatic rvCorePkg::dmemReqT storeOf(input logic [6:0] wordAddr,
            input rvCorePkg::wordT data);
        rvCorePkg::dmemReqT q;
        q.wordAddr  = wordAddr;
        q.writeData = data;
        q.writeEn   = 1'b1;
        return q;
    endfunction

    // current instruction's commit, one edge, then the new pc
    task automatic execute(input string what, input rvCorePkg::retireT expRetire,
            input rvCorePkg::dmemReqT expReq, input rvCorePkg::wordT expPc);
        checkRetire(what, retire, expRetire);
        checkReq(what, dmemReq, expReq);
        step();
        checkWord({what, " next pc"}, pc, expPc);
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic testFetch();
        rvCorePkg::wordT expPc;
        holdReset();
        fillRom();
        fillRam();
        releaseReset();
        checkWord("pc after reset", pc, 32'd0);
        expPc = 32'd0;
        for (int n = 0; n < 6; n++) begin
            expPc = expPc + 32'd4;
            execute("no-op", '0, '0, expPc);
        end
        waitForPc(32'd100, 30);
    endtask

    task automatic testAluOps();
        rvCorePkg::wordT a, b, c, d;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        d = $random(seed);
        // one positive and one negative operand for slt
        a[31] = 1'b0;
        d[31] = 1'b1;
        holdReset();
        fillRom();
        fillRam();
        ram[1] <= toBigEndian(a);
        ram[2] <= toBigEndian(b);
        ram[3] <= toBigEndian(c);
        ram[4] <= toBigEndian(d);
        putInstr(0, lwInstr(5'd1, 12'd4, 5'd0));
        putInstr(1, lwInstr(5'd2, 12'd8, 5'd0));
        putInstr(2, lwInstr(5'd3, 12'd12, 5'd0));
        putInstr(3, lwInstr(5'd4, 12'd16, 5'd0));
        putInstr(4, rInstr(7'h00, rvIsaPkg::f3AddSub, 5'd5, 5'd1, 5'd2));
        putInstr(5, rInstr(7'h20, rvIsaPkg::f3AddSub, 5'd6, 5'd1, 5'd2));
        putInstr(6, rInstr(7'h00, rvIsaPkg::f3And, 5'd7, 5'd1, 5'd3));
        putInstr(7, rInstr(7'h00, rvIsaPkg::f3Or, 5'd8, 5'd2, 5'd3));
        putInstr(8, rInstr(7'h00, rvIsaPkg::f3Slt, 5'd9, 5'd4, 5'd1));
        putInstr(9, rInstr(7'h00, rvIsaPkg::f3Slt, 5'd10, 5'd1, 5'd4));
        releaseReset();
        execute("lw x1", writeOf(5'd1, a), '0, 32'd4);
        execute("lw x2", writeOf(5'd2, b), '0, 32'd8);
        execute("lw x3", writeOf(5'd3, c), '0, 32'd12);
        execute("lw x4", writeOf(5'd4, d), '0, 32'd16);
        execute("add", writeOf(5'd5, a + b), '0, 32'd20);
        execute("sub", writeOf(5'd6, a - b), '0, 32'd24);
        execute("and", writeOf(5'd7, a & c), '0, 32'd28);
        execute("or", writeOf(5'd8, b | c), '0, 32'd32);
        // negative below positive, and the reverse
        execute("slt neg", writeOf(5'd9, 32'd1), '0, 32'd36);
        execute("slt pos", writeOf(5'd10, 32'd0), '0, 32'd40);
    endtask

    task automatic testStores();
        rvCorePkg::wordT v;
        v = $random(seed);
        holdReset();
        fillRom();
        fillRam();
        ram[5] <= toBigEndian(v);
        ram[6] <= toBigEndian(32'h0000_0040);
        putInstr(0, lwInstr(5'd1, 12'd20, 5'd0));
        putInstr(1, lwInstr(5'd2, 12'd24, 5'd0));
        putInstr(2, swInstr(5'd1, 12'd12, 5'd2));
        putInstr(3, swInstr(5'd1, 12'hffc, 5'd2));
        putInstr(4, lwInstr(5'd3, 12'd12, 5'd2));
        putInstr(5, lwInstr(5'd4, 12'hffc, 5'd2));
        releaseReset();
        execute("lw x1", writeOf(5'd1, v), '0, 32'd4);
        execute("lw x2", writeOf(5'd2, 32'h0000_0040), '0, 32'd8);
        // 0x40 + 12 is word 0x13, 0x40 - 4 is word 0x0f
        execute("sw +12", '0, storeOf(7'h13, toBigEndian(v)), 32'd12);
        checkWord("ram word 0x13", ram[7'h13], toBigEndian(v));
        execute("sw -4", '0, storeOf(7'h0f, toBigEndian(v)), 32'd16);
        checkWord("ram word 0x0f", ram[7'h0f], toBigEndian(v));
        execute("lw back +12", writeOf(5'd3, v), '0, 32'd20);
        execute("lw back -4", writeOf(5'd4, v), '0, 32'd24);
    endtask

    task automatic testBeq();
        rvCorePkg::wordT v;
        v = $random(seed);
        holdReset();
        fillRom();
        fillRam();
        ram[7] <= toBigEndian(v);
        ram[8] <= toBigEndian(v ^ 32'h0000_0100);
        putInstr(0, lwInstr(5'd1, 12'd28, 5'd0));
        putInstr(1, lwInstr(5'd2, 12'd28, 5'd0));
        putInstr(2, lwInstr(5'd3, 12'd32, 5'd0));
        putInstr(3, beqInstr(5'd1, 5'd2, 13'd16));
        putInstr(7, beqInstr(5'd1, 5'd3, 13'd8));
        putInstr(8, beqInstr(5'd0, 5'd0, 13'h1fe0));
        releaseReset();
        execute("lw x1", writeOf(5'd1, v), '0, 32'd4);
        execute("lw x2", writeOf(5'd2, v), '0, 32'd8);
        execute("lw x3", writeOf(5'd3, v ^ 32'h0000_0100), '0, 32'd12);
        execute("beq equal", '0, '0, 32'd28);
        execute("beq differ", '0, '0, 32'd32);
        // backwards by 32
        execute("beq back", '0, '0, 32'd0);
        execute("lw x1 again", writeOf(5'd1, v), '0, 32'd4);
    endtask

    task automatic testJumps();
        holdReset();
        fillRom();
        fillRam();
        ram[9] <= toBigEndian(32'h0000_0040);
        putInstr(0, jalInstr(5'd1, 21'd12));
        putInstr(3, lwInstr(5'd2, 12'd36, 5'd0));
        putInstr(4, jalrInstr(5'd3, 5'd2, 12'd8));
        putInstr(18, jalrInstr(5'd4, 5'd2, 12'hff0));
        putInstr(12, jalInstr(5'd0, 21'h1fffd0));
        releaseReset();
        execute("jal fwd", writeOf(5'd1, 32'd4), '0, 32'd12);
        execute("lw x2", writeOf(5'd2, 32'h0000_0040), '0, 32'd16);
        execute("jalr +8", writeOf(5'd3, 32'd20), '0, 32'h48);
        execute("jalr -16", writeOf(5'd4, 32'h4c), '0, 32'h30);
        execute("jal back", writeOf(5'd0, 32'h34), '0, 32'd0);
    endtask

    task automatic testX0();
        rvCorePkg::wordT v, w;
        v = $random(seed);
        w = $random(seed);
        v[0] = 1'b1;
        holdReset();
        fillRom();
        fillRam();
        ram[10] <= toBigEndian(v);
        ram[11] <= toBigEndian(w);
        putInstr(0, lwInstr(5'd0, 12'd40, 5'd0));
        putInstr(1, lwInstr(5'd1, 12'd44, 5'd0));
        putInstr(2, rInstr(7'h00, rvIsaPkg::f3AddSub, 5'd2, 5'd0, 5'd1));
        putInstr(3, rInstr(7'h00, rvIsaPkg::f3AddSub, 5'd0, 5'd1, 5'd1));
        putInstr(4, rInstr(7'h00, rvIsaPkg::f3AddSub, 5'd3, 5'd0, 5'd0));
        putInstr(5, rInstr(7'h00, rvIsaPkg::f3Or, 5'd4, 5'd0, 5'd0));
        releaseReset();
        // writes aimed at x0 still show on retire
        execute("lw x0", writeOf(5'd0, v), '0, 32'd4);
        execute("lw x1", writeOf(5'd1, w), '0, 32'd8);
        execute("add x0+x1", writeOf(5'd2, w), '0, 32'd12);
        execute("add into x0", writeOf(5'd0, w + w), '0, 32'd16);
        execute("add x0+x0", writeOf(5'd3, 32'd0), '0, 32'd20);
        execute("or x0|x0", writeOf(5'd4, 32'd0), '0, 32'd24);
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        testFetch();
        testAluOps();
        testStores();
        testBeq();
        testJumps();
        testX0();
        finishRun();
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the riscvCore testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module riscvCoreTb -f tb.f -o riscvCoreSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/riscvCoreSim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# result comes from the log, not the exit status
if grep -qx "Finished with no errors" "$log"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

/* rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

    typedef logic [rvIsaPkg::xlen-1:0] wordT;

    // data memory word index, taken from address bits 8:2
    localparam int dmemAddrW = 7;

    // writeback source
    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbLink
    } wbSelT;

    // ====================
    // decoded control
    // ====================
    typedef struct packed {
        logic              regWrite;
        logic              aluSrcImm;
        logic              memWrite;
        logic              branch;
        logic              jal;
        logic              jalr;
        wbSelT             wbSel;
        rvIsaPkg::aluOpT   aluOp;
    } ctrlT;

    // request to the external data memory
    typedef struct packed {
        logic [dmemAddrW-1:0] wordAddr;
        wordT                 writeData;  // already in memory byte order
        logic                 writeEn;
    } dmemReqT;

    // what the current instruction writes back
    typedef struct packed {
        logic              regWrite;
        rvIsaPkg::regAddrT rd;
        wordT              data;
    } retireT;

endpackage

`default_nettype wire

/* rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    // ====================
    // widths fixed by the isa
    // ====================
    localparam int xlen = 32;

    typedef logic [4:0] regAddrT;

    // major opcodes, bits 6:0
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opReg    = 7'b0110011;

    // funct3 for the r-type subset
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // ====================
    // instruction formats
    // ====================
    typedef struct packed {
        logic [6:0] funct7;
        regAddrT    rs2;
        regAddrT    rs1;
        logic [2:0] funct3;
        regAddrT    rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm11to0;
        regAddrT     rs1;
        logic [2:0]  funct3;
        regAddrT     rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] imm11to5;
        regAddrT    rs2;
        regAddrT    rs1;
        logic [2:0] funct3;
        logic [4:0] imm4to0;
        logic [6:0] opcode;
    } sTypeT;

    // branch offset is scattered, bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        regAddrT    rs2;
        regAddrT    rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        regAddrT    rd;
        logic [6:0] opcode;
    } jTypeT;

    // one fetched word, read through whichever format applies
    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        jTypeT j;
    } instrU;

    typedef enum logic [2:0] {
        aluAnd,
        aluOr,
        aluAdd,
        aluSub,
        aluSlt
    } aluOpT;

endpackage

`default_nettype wire

/* tb.f */
rvIsaPkg.sv
rvCorePkg.sv
controlDecoder.sv
immGen.sv
regFile.sv
alu.sv
pcUnit.sv
riscvCore.sv
coreChecks_props.sv
riscvCoreTb.sv
